/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

//////////////////////////////
// bank geometry
//////////////////////////////
`define MEM_COLS    8
`define MEM_LINES   512
`define MEM_WORD_W  64
`define MEM_ELEM_W  16
`define MEM_IDX_W   14
`define MEM_LINE_W  9

//////////////////////////////
// region map, in lines
//////////////////////////////
`define MEM_OFF_B      0
`define MEM_OFF_S      336
`define MEM_OFF_CELLS  420   // seeds, salt and other state words

`define MEM_LEN_B      336
`define MEM_LEN_S      84
`define MEM_LEN_CELLS  8

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    MODE_WORD,   // one 64-bit word per index
    MODE_ROW,    // all columns of a line
    MODE_ELEM    // one 16-bit element per index
  } mem_mode_e;

  typedef enum logic [1:0] {
    REGION_B,
    REGION_S,
    REGION_CELLS
  } mem_region_e;

  typedef logic [`MEM_IDX_W-1:0]               mem_index_t;
  typedef logic [`MEM_LINE_W-1:0]              line_t;
  typedef logic [`MEM_COLS-1:0]                col_en_t;
  typedef logic [`MEM_WORD_W/8-1:0]            byte_en_t;
  typedef logic [`MEM_WORD_W-1:0]              word_t;
  typedef logic [`MEM_COLS*`MEM_WORD_W-1:0]    row_t;
  typedef logic [`MEM_ELEM_W-1:0]              elem_t;

endpackage

`default_nettype wire

/* bank_if.sv */
`default_nettype none

interface bank_if;
  import mem_pkg::*;

  line_t    line;
  col_en_t  col_en;
  byte_en_t byte_en;
  row_t     wdata;
  row_t     rdata;   // masked, two cycles after the request

  modport port (
    output line,
    output col_en,
    output byte_en,
    output wdata,
    input  rdata
  );

  modport bank (
    input  line,
    input  col_en,
    input  byte_en,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* bram_column.sv */
`default_nettype none

`include "mem_defines.svh"

module bram_column (
  input  wire               clk,
  input  wire               i_rd_en,
  input  mem_pkg::line_t    i_rd_line,
  output mem_pkg::word_t    o_rd_data,
  input  wire               i_wr_en,
  input  mem_pkg::line_t    i_wr_line,
  input  mem_pkg::byte_en_t i_wr_byte_en,
  input  mem_pkg::word_t    i_wr_data
);
  import mem_pkg::*;

  word_t mem [`MEM_LINES];
  word_t rd_q1;
  word_t rd_q2;

  //////////////////////////////
  // write side
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `MEM_WORD_W/8; b++) begin
        if (i_wr_byte_en[b]) begin
          mem[i_wr_line][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_line];   // old data on a same-line write
    end
    rd_q2 <= rd_q1;              // output register
  end

  assign o_rd_data = rd_q2;

endmodule

`default_nettype wire

/* bram_bank.sv */
`default_nettype none

`include "mem_defines.svh"

module bram_bank (
  input wire    clk,
  input wire    i_arst_n,
  bank_if.bank  rd,
  bank_if.bank  wr
);
  import mem_pkg::*;

  col_en_t  col_en_d1;
  col_en_t  col_en_d2;
  byte_en_t byte_en_d1;
  byte_en_t byte_en_d2;
  word_t    rd_raw [`MEM_COLS];

  genvar c;
  genvar b;

  generate
    for (c = 0; c < `MEM_COLS; c++) begin : g_col
      bram_column u_col (
        .clk          (clk),
        .i_rd_en      (rd.col_en[c]),
        .i_rd_line    (rd.line),
        .o_rd_data    (rd_raw[c]),
        .i_wr_en      (wr.col_en[c]),
        .i_wr_line    (wr.line),
        .i_wr_byte_en (wr.byte_en),
        .i_wr_data    (wr.wdata[c*`MEM_WORD_W +: `MEM_WORD_W])
      );

      for (b = 0; b < `MEM_WORD_W/8; b++) begin : g_byte
        assign rd.rdata[c*`MEM_WORD_W + b*8 +: 8] =
          rd_raw[c][b*8 +: 8] & {8{col_en_d2[c] & byte_en_d2[b]}};
      end
    end
  endgenerate

  //////////////////////////////
  // enables follow the data
  //////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      col_en_d1  <= '0;
      col_en_d2  <= '0;
      byte_en_d1 <= '0;
      byte_en_d2 <= '0;
    end else begin
      col_en_d1  <= rd.col_en;
      col_en_d2  <= col_en_d1;
      byte_en_d1 <= rd.byte_en;
      byte_en_d2 <= byte_en_d1;
    end
  end

  assign wr.rdata = '0;   // nothing comes back on the write side

  a_mask_known: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !$isunknown({col_en_d2, byte_en_d2})
  );

endmodule

`default_nettype wire

/* mem_addr_map.sv */
`default_nettype none

`include "mem_defines.svh"

module mem_addr_map (
  input  mem_pkg::mem_region_e i_region,
  input  mem_pkg::mem_mode_e   i_mode,
  input  mem_pkg::mem_index_t  i_index,
  output mem_pkg::line_t       o_line,
  output mem_pkg::col_en_t     o_col_en,
  output mem_pkg::byte_en_t    o_byte_en,
  output mem_pkg::mem_index_t  o_index_next,
  output logic                 o_has_next
);
  import mem_pkg::*;

  line_t      off;
  mem_index_t len;
  mem_index_t last;

  always_comb begin
    case (i_region)
      REGION_S: begin
        off = line_t'(`MEM_OFF_S);
        len = mem_index_t'(`MEM_LEN_S);
      end
      REGION_CELLS: begin
        off = line_t'(`MEM_OFF_CELLS);
        len = mem_index_t'(`MEM_LEN_CELLS);
      end
      default: begin
        off = line_t'(`MEM_OFF_B);
        len = mem_index_t'(`MEM_LEN_B);
      end
    endcase
  end

  //////////////////////////////
  // index to line and lanes
  //////////////////////////////
  always_comb begin
    case (i_mode)
      MODE_ROW: begin
        o_line    = off + line_t'(i_index);
        o_col_en  = '1;
        o_byte_en = '1;
        last      = len - 1'b1;
      end
      MODE_ELEM: begin
        o_line    = off + line_t'(i_index >> 5);          // 32 elems per line
        o_col_en  = col_en_t'(1) << i_index[4:2];
        o_byte_en = byte_en_t'(2'b11) << {i_index[1:0], 1'b0};
        last      = (len << 5) - 1'b1;
      end
      default: begin
        o_line    = off + line_t'(i_index >> 3);
        o_col_en  = col_en_t'(1) << i_index[2:0];
        o_byte_en = '1;
        last      = (len << 3) - 1'b1;
      end
    endcase
  end

  assign o_index_next = i_index + 1'b1;
  assign o_has_next   = (i_index != last);

endmodule

`default_nettype wire

/* mem_write_port.sv */
`default_nettype none

`include "mem_defines.svh"

module mem_write_port (
  input  wire                  i_wr_en,
  input  mem_pkg::mem_region_e i_wr_region,
  input  mem_pkg::mem_mode_e   i_wr_mode,
  input  mem_pkg::mem_index_t  i_wr_index,
  input  mem_pkg::word_t       i_wr_word,
  input  mem_pkg::row_t        i_wr_row,
  input  mem_pkg::elem_t       i_wr_elem,
  output mem_pkg::mem_index_t  o_wr_index_next,
  output logic                 o_wr_has_next,
  bank_if.port                 bus
);
  import mem_pkg::*;

  col_en_t col_en;

  mem_addr_map u_map (
    .i_region     (i_wr_region),
    .i_mode       (i_wr_mode),
    .i_index      (i_wr_index),
    .o_line       (bus.line),
    .o_col_en     (col_en),
    .o_byte_en    (bus.byte_en),
    .o_index_next (o_wr_index_next),
    .o_has_next   (o_wr_has_next)
  );

  assign bus.col_en = col_en & {`MEM_COLS{i_wr_en}};

  // spread the data so any enabled lane sees it
  always_comb begin
    case (i_wr_mode)
      MODE_ROW:  bus.wdata = i_wr_row;
      MODE_ELEM: bus.wdata = {(`MEM_COLS*`MEM_WORD_W/`MEM_ELEM_W){i_wr_elem}};
      default:   bus.wdata = {`MEM_COLS{i_wr_word}};
    endcase
  end

endmodule

`default_nettype wire

/* mem_read_port.sv */
`default_nettype none

`include "mem_defines.svh"

module mem_read_port (
  input  wire                  clk,
  input  wire                  i_arst_n,
  input  wire                  i_rd_en,
  input  mem_pkg::mem_region_e i_rd_region,
  input  mem_pkg::mem_mode_e   i_rd_mode,
  input  mem_pkg::mem_index_t  i_rd_index,
  output mem_pkg::mem_index_t  o_rd_index_next,
  output logic                 o_rd_has_next,
  output logic                 o_rd_valid,
  output mem_pkg::word_t       o_rd_word,
  output mem_pkg::row_t        o_rd_row,
  output mem_pkg::elem_t       o_rd_elem,
  bank_if.port                 bus
);
  import mem_pkg::*;

  col_en_t  col_en;
  byte_en_t byte_en;
  logic     valid_q1;

  mem_addr_map u_map (
    .i_region     (i_rd_region),
    .i_mode       (i_rd_mode),
    .i_index      (i_rd_index),
    .o_line       (bus.line),
    .o_col_en     (col_en),
    .o_byte_en    (byte_en),
    .o_index_next (o_rd_index_next),
    .o_has_next   (o_rd_has_next)
  );

  assign bus.col_en  = col_en & {`MEM_COLS{i_rd_en}};
  assign bus.byte_en = byte_en & {(`MEM_WORD_W/8){i_rd_en}};
  assign bus.wdata   = '0;   // read side never writes

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q1   <= 1'b0;
      o_rd_valid <= 1'b0;
    end else begin
      valid_q1   <= i_rd_en;
      o_rd_valid <= valid_q1;   // matches ram latency
    end
  end

  //////////////////////////////
  // merge masked row
  //////////////////////////////
  assign o_rd_row = bus.rdata;

  always_comb begin
    o_rd_word = '0;
    for (int c = 0; c < `MEM_COLS; c++) begin
      o_rd_word |= bus.rdata[c*`MEM_WORD_W +: `MEM_WORD_W];   // one col left
    end
  end

  always_comb begin
    o_rd_elem = '0;
    for (int l = 0; l < `MEM_WORD_W/`MEM_ELEM_W; l++) begin
      o_rd_elem |= o_rd_word[l*`MEM_ELEM_W +: `MEM_ELEM_W];
    end
  end

  // bank lanes open only in the cycle that valid marks
  a_valid_lat: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !o_rd_valid |-> (bus.rdata == '0)
  );

endmodule

`default_nettype wire

/* main_mem.sv */
`default_nettype none

module main_mem (
  input  wire                  clk,
  input  wire                  i_arst_n,

  // write side
  input  wire                  i_wr_en,
  input  mem_pkg::mem_region_e i_wr_region,
  input  mem_pkg::mem_mode_e   i_wr_mode,
  input  mem_pkg::mem_index_t  i_wr_index,
  input  mem_pkg::word_t       i_wr_word,
  input  mem_pkg::row_t        i_wr_row,
  input  mem_pkg::elem_t       i_wr_elem,
  output mem_pkg::mem_index_t  o_wr_index_next,
  output logic                 o_wr_has_next,

  // read side
  input  wire                  i_rd_en,
  input  mem_pkg::mem_region_e i_rd_region,
  input  mem_pkg::mem_mode_e   i_rd_mode,
  input  mem_pkg::mem_index_t  i_rd_index,
  output mem_pkg::mem_index_t  o_rd_index_next,
  output logic                 o_rd_has_next,
  output logic                 o_rd_valid,
  output mem_pkg::word_t       o_rd_word,
  output mem_pkg::row_t        o_rd_row,
  output mem_pkg::elem_t       o_rd_elem
);

  bank_if wr_bus ();
  bank_if rd_bus ();

  bram_bank u_bank (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .rd       (rd_bus.bank),
    .wr       (wr_bus.bank)
  );

  mem_write_port u_wr (
    .i_wr_en         (i_wr_en),
    .i_wr_region     (i_wr_region),
    .i_wr_mode       (i_wr_mode),
    .i_wr_index      (i_wr_index),
    .i_wr_word       (i_wr_word),
    .i_wr_row        (i_wr_row),
    .i_wr_elem       (i_wr_elem),
    .o_wr_index_next (o_wr_index_next),
    .o_wr_has_next   (o_wr_has_next),
    .bus             (wr_bus.port)
  );

  mem_read_port u_rd (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_rd_en         (i_rd_en),
    .i_rd_region     (i_rd_region),
    .i_rd_mode       (i_rd_mode),
    .i_rd_index      (i_rd_index),
    .o_rd_index_next (o_rd_index_next),
    .o_rd_has_next   (o_rd_has_next),
    .o_rd_valid      (o_rd_valid),
    .o_rd_word       (o_rd_word),
    .o_rd_row        (o_rd_row),
    .o_rd_elem       (o_rd_elem),
    .bus             (rd_bus.port)
  );

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

`include "mem_defines.svh"

module tb_checker (
  input wire                  clk,
  input wire                  i_arst_n,
  input wire                  i_wr_en,
  input mem_pkg::mem_region_e i_wr_region,
  input mem_pkg::mem_mode_e   i_wr_mode,
  input mem_pkg::mem_index_t  i_wr_index,
  input mem_pkg::word_t       i_wr_word,
  input mem_pkg::row_t        i_wr_row,
  input mem_pkg::elem_t       i_wr_elem,
  input mem_pkg::mem_index_t  i_wr_index_next,
  input wire                  i_wr_has_next,
  input wire                  i_rd_en,
  input mem_pkg::mem_region_e i_rd_region,
  input mem_pkg::mem_mode_e   i_rd_mode,
  input mem_pkg::mem_index_t  i_rd_index,
  input mem_pkg::mem_index_t  i_rd_index_next,
  input wire                  i_rd_has_next,
  input wire                  i_rd_valid,
  input mem_pkg::word_t       i_rd_word,
  input mem_pkg::row_t        i_rd_row,
  input mem_pkg::elem_t       i_rd_elem,
  output int                  o_err_data,
  output int                  o_err_valid,
  output int                  o_err_index,
  output int                  o_pending
);
  timeunit 1ns;
  timeprecision 100ps;

  import mem_pkg::*;

  word_t      model [`MEM_COLS][`MEM_LINES];
  row_t       exp_q [$];
  logic [1:0] rd_hist;   // read enables of the last two edges
  int         err_data  = 0;
  int         err_valid = 0;
  int         err_index = 0;
  int         pending   = 0;

  assign o_err_data  = err_data;
  assign o_err_valid = err_valid;
  assign o_err_index = err_index;
  assign o_pending   = pending;

  //////////////////////////////
  // region and shape rules
  //////////////////////////////
  function automatic int region_off(mem_region_e r);
    case (r)
      REGION_S:     return `MEM_OFF_S;
      REGION_CELLS: return `MEM_OFF_CELLS;
      default:      return `MEM_OFF_B;
    endcase
  endfunction

  function automatic int region_len(mem_region_e r);
    case (r)
      REGION_S:     return `MEM_LEN_S;
      REGION_CELLS: return `MEM_LEN_CELLS;
      default:      return `MEM_LEN_B;
    endcase
  endfunction

  function automatic int per_line(mem_mode_e m);
    case (m)
      MODE_ROW:  return 1;
      MODE_ELEM: return 32;
      default:   return 8;
    endcase
  endfunction

  function automatic int line_of(mem_region_e r, mem_mode_e m, int idx);
    return region_off(r) + idx / per_line(m);
  endfunction

  function automatic bit lane_on(mem_mode_e m, int idx, int c, int b);
    case (m)
      MODE_ROW:  return 1'b1;
      MODE_ELEM: return (c == (idx / 4) % 8) && (b / 2 == idx % 4);
      default:   return c == idx % 8;
    endcase
  endfunction

  function automatic row_t expected_row(mem_region_e r, mem_mode_e m, int idx);
    row_t row;
    int   line;
    row  = '0;
    line = line_of(r, m, idx);
    for (int c = 0; c < `MEM_COLS; c++) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_on(m, idx, c, b)) begin
          row[c*64 + b*8 +: 8] = model[c][line][b*8 +: 8];
        end
      end
    end
    return row;
  endfunction

  function automatic word_t fold_word(row_t row);
    word_t w;
    w = '0;
    for (int c = 0; c < `MEM_COLS; c++) begin
      w |= row[c*64 +: 64];
    end
    return w;
  endfunction

  function automatic elem_t fold_elem(word_t w);
    return w[15:0] | w[31:16] | w[47:32] | w[63:48];
  endfunction

  //////////////////////////////
  // checks and model update
  //////////////////////////////
  task automatic apply_write();
    int         line;
    logic [7:0] src;
    line = line_of(i_wr_region, i_wr_mode, i_wr_index);
    for (int c = 0; c < `MEM_COLS; c++) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_on(i_wr_mode, i_wr_index, c, b)) begin
          case (i_wr_mode)
            MODE_ROW:  src = i_wr_row[c*64 + b*8 +: 8];
            MODE_ELEM: src = i_wr_elem[(b % 2)*8 +: 8];
            default:   src = i_wr_word[b*8 +: 8];
          endcase
          model[c][line][b*8 +: 8] = src;
        end
      end
    end
  endtask

  task automatic compare_read();
    row_t exp;
    if (exp_q.size() == 0) begin
      $display("o_rd_valid went high with no read outstanding");
      err_valid++;
      return;
    end
    exp = exp_q.pop_front();
    if (i_rd_row !== exp) begin
      $display("[FAIL] o_rd_row exp=%h got=%h", exp, i_rd_row);
      err_data++;
    end
    if (i_rd_word !== fold_word(exp)) begin
      $display("[FAIL] o_rd_word exp=%h got=%h", fold_word(exp), i_rd_word);
      err_data++;
    end
    if (i_rd_elem !== fold_elem(fold_word(exp))) begin
      $display("[FAIL] o_rd_elem exp=%h got=%h", fold_elem(fold_word(exp)), i_rd_elem);
      err_data++;
    end
  endtask

  task automatic check_walk(string side, mem_region_e r, mem_mode_e m, mem_index_t idx,
                            mem_index_t idx_next, logic has_next);
    mem_index_t exp_next;
    logic       exp_has;
    exp_next = mem_index_t'(idx + 1);
    exp_has  = (int'(idx) != region_len(r) * per_line(m) - 1);
    if (idx_next !== exp_next) begin
      $display("[FAIL] o_%s_index_next exp=%h got=%h", side, exp_next, idx_next);
      err_index++;
    end
    if (has_next !== exp_has) begin
      $display("[FAIL] o_%s_has_next exp=%h got=%h", side, exp_has, has_next);
      err_index++;
    end
  endtask

  always @(posedge clk) begin
    if (!i_arst_n) begin
      if (i_rd_valid !== 1'b0) begin
        $display("o_rd_valid is not low during reset");
        err_valid++;
      end
      rd_hist = 2'b00;
    end else begin
      if (i_rd_valid !== rd_hist[1]) begin
        $display("[FAIL] o_rd_valid exp=%h got=%h", rd_hist[1], i_rd_valid);
        err_valid++;
      end
      if (i_rd_valid === 1'b1) begin
        compare_read();
      end
      check_walk("wr", i_wr_region, i_wr_mode, i_wr_index, i_wr_index_next, i_wr_has_next);
      check_walk("rd", i_rd_region, i_rd_mode, i_rd_index, i_rd_index_next, i_rd_has_next);
      if (i_rd_en) begin
        exp_q.push_back(expected_row(i_rd_region, i_rd_mode, i_rd_index));   // old data
      end
      if (i_wr_en) begin
        apply_write();
      end
      rd_hist = {rd_hist[0], i_rd_en};
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* tb_main_mem.sv */
`default_nettype none

`include "mem_defines.svh"

module tb_main_mem;
  timeunit 1ns;
  timeprecision 100ps;

  import mem_pkg::*;

  localparam int NUM_CYCLES  = 2000;
  localparam int DRAIN_LIMIT = 16;

  logic        clk;
  logic        i_arst_n;
  logic        i_wr_en;
  mem_region_e i_wr_region;
  mem_mode_e   i_wr_mode;
  mem_index_t  i_wr_index;
  word_t       i_wr_word;
  row_t        i_wr_row;
  elem_t       i_wr_elem;
  mem_index_t  o_wr_index_next;
  logic        o_wr_has_next;
  logic        i_rd_en;
  mem_region_e i_rd_region;
  mem_mode_e   i_rd_mode;
  mem_index_t  i_rd_index;
  mem_index_t  o_rd_index_next;
  logic        o_rd_has_next;
  logic        o_rd_valid;
  word_t       o_rd_word;
  row_t        o_rd_row;
  elem_t       o_rd_elem;

  int          err_data;
  int          err_valid;
  int          err_index;
  int          err_drain;
  int          pending;
  logic [31:0] seed = 32'h8952;

  main_mem DUT (.*);

  tb_checker u_check (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_wr_en         (i_wr_en),
    .i_wr_region     (i_wr_region),
    .i_wr_mode       (i_wr_mode),
    .i_wr_index      (i_wr_index),
    .i_wr_word       (i_wr_word),
    .i_wr_row        (i_wr_row),
    .i_wr_elem       (i_wr_elem),
    .i_wr_index_next (o_wr_index_next),
    .i_wr_has_next   (o_wr_has_next),
    .i_rd_en         (i_rd_en),
    .i_rd_region     (i_rd_region),
    .i_rd_mode       (i_rd_mode),
    .i_rd_index      (i_rd_index),
    .i_rd_index_next (o_rd_index_next),
    .i_rd_has_next   (o_rd_has_next),
    .i_rd_valid      (o_rd_valid),
    .i_rd_word       (o_rd_word),
    .i_rd_row        (o_rd_row),
    .i_rd_elem       (o_rd_elem),
    .o_err_data      (err_data),
    .o_err_valid     (err_valid),
    .o_err_index     (err_index),
    .o_pending       (pending)
  );

  //////////////////////////////
  // random source
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function row_t random_row();
    row_t r;
    for (int i = 0; i < 16; i++) begin
      r[i*32 +: 32] = next_rand();
    end
    return r;
  endfunction

  function automatic mem_region_e pick_region(input logic [31:0] v);
    case (v % 3)
      0:       return REGION_B;
      1:       return REGION_S;
      default: return REGION_CELLS;
    endcase
  endfunction

  function automatic mem_mode_e pick_mode(input logic [31:0] v);
    case (v % 3)
      0:       return MODE_WORD;
      1:       return MODE_ROW;
      default: return MODE_ELEM;
    endcase
  endfunction

  // number of valid indices in a region for a shape
  function automatic int index_span(mem_region_e r, mem_mode_e m);
    int len;
    int per;
    case (r)
      REGION_S:     len = `MEM_LEN_S;
      REGION_CELLS: len = `MEM_LEN_CELLS;
      default:      len = `MEM_LEN_B;
    endcase
    case (m)
      MODE_ROW:  per = 1;
      MODE_ELEM: per = 32;
      default:   per = 8;
    endcase
    return len * per;
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic drive_idle();
    i_wr_en     = 1'b0;
    i_wr_region = REGION_B;
    i_wr_mode   = MODE_WORD;
    i_wr_index  = '0;
    i_wr_word   = '0;
    i_wr_row    = '0;
    i_wr_elem   = '0;
    i_rd_en     = 1'b0;
    i_rd_region = REGION_B;
    i_rd_mode   = MODE_WORD;
    i_rd_index  = '0;
  endtask

  task automatic fill_regions();
    mem_region_e r;
    r = r.first();
    repeat (r.num()) begin
      for (int i = 0; i < index_span(r, MODE_ROW); i++) begin
        @(posedge clk);
        #1;
        i_wr_en     = 1'b1;
        i_wr_region = r;
        i_wr_mode   = MODE_ROW;
        i_wr_index  = mem_index_t'(i);
        i_wr_row    = random_row();
      end
      r = r.next();
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = next_rand();
    i_wr_en     = r[0];
    i_rd_en     = r[1];
    i_wr_region = pick_region(next_rand());
    i_wr_mode   = pick_mode(next_rand());
    i_wr_index  = mem_index_t'(next_rand() % index_span(i_wr_region, i_wr_mode));
    i_wr_word   = {next_rand(), next_rand()};
    i_wr_row    = random_row();
    i_wr_elem   = elem_t'(next_rand());
    i_rd_region = pick_region(next_rand());
    i_rd_mode   = pick_mode(next_rand());
    i_rd_index  = mem_index_t'(next_rand() % index_span(i_rd_region, i_rd_mode));
    if (r[7:5] == 3'd0) begin   // end of the walk
      i_wr_index = mem_index_t'(index_span(i_wr_region, i_wr_mode) - 1);
    end
    if (r[10:8] == 3'd0) begin
      i_rd_index = mem_index_t'(index_span(i_rd_region, i_rd_mode) - 1);
    end
    if (r[4:2] == 3'd0) begin   // same address as the write
      i_rd_region = i_wr_region;
      i_rd_mode   = i_wr_mode;
      i_rd_index  = i_wr_index;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    int waited;
    err_drain = 0;
    i_arst_n  = 1'b1;
    drive_idle();
    #1 i_arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 i_arst_n = 1'b1;
    fill_regions();
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      #1 drive_random();
    end
    @(posedge clk);
    #1 drive_idle();
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #1 waited++;
    end
    if (pending != 0) begin
      $display("timed out waiting for %0d outstanding reads to return", pending);
      err_drain = 1;
    end
    $display("errors: data %0d, valid %0d, index %0d, drain %0d",
             err_data, err_valid, err_index, err_drain);
    if (err_data + err_valid + err_index + err_drain == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
mem_pkg.sv
bank_if.sv
bram_column.sv
bram_bank.sv
mem_addr_map.sv
mem_write_port.sv
mem_read_port.sv
main_mem.sv
tb_checker.sv
tb_main_mem.sv

/* Bender.yml */
package:
  name: main_mem

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - bank_if.sv
      - bram_column.sv
      - bram_bank.sv
      - mem_addr_map.sv
      - mem_write_port.sv
      - mem_read_port.sv
      - main_mem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_checker.sv
      - tb_main_mem.sv
